// ==== source/lsu_params.svh ====
// Width and depth constants of the load/store unit
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

//////////////////////////////////////////////////
// Bus geometry

`define LSU_DATA_W 32          // Data and address width, one word
`define LSU_BE_W 4             // Byte lanes per word

//////////////////////////////////////////////////
// Transaction tracking

// Bus allows two accesses in flight before the request is held off
`define LSU_MAX_OUTSTANDING 2
`define LSU_CNT_W 2            // Holds 0 .. LSU_MAX_OUTSTANDING

`endif

// ==== source/lsu_pkg.sv ====
// Access size encoding and per-transaction control record of the load/store unit
`default_nettype none

package lsu_pkg;

  //////////////////////////////////////////////////
  // Access size

  // Encoding follows funct3[1:0] of the load/store opcodes
  typedef enum logic [1:0] {
    BYTE = 2'b00,              // lb, lbu, sb
    HALF = 2'b01,              // lh, lhu, sh
    WORD = 2'b10               // lw, sw
  } lsu_size_e;

  //////////////////////////////////////////////////
  // Response control

  // Captured when an access leaves the request stage,
  // consumed when its rvalid comes back
  typedef struct packed {
    lsu_size_e  size;          // Access size
    logic       sign_ext;      // Sign extend loaded byte/halfword
    logic       we;            // Store, response carries no data
    logic [1:0] offset;        // Byte offset of the original address
    logic       last;          // Low for the first half of a split access
  } lsu_wb_ctrl_t;

endpackage

`default_nettype wire

// ==== source/lsu_request_stage.sv ====
// Request stage with address generation, split detection, byte enables and store data rotation
`default_nettype none
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_request_stage
(
  input  wire logic                     clk,
  input  wire logic                     rst_n,

  // Core side
  input  wire logic                     lsu_en_i,      // Access present
  input  wire logic [`LSU_DATA_W-1:0]   operand_a_i,   // Base
  input  wire logic [`LSU_DATA_W-1:0]   operand_b_i,   // Offset
  input  wire logic                     use_incr_i,    // Add offset to base
  input  wire lsu_pkg::lsu_size_e       size_i,
  input  wire logic                     sign_ext_i,
  input  wire logic                     we_i,
  input  wire logic [`LSU_DATA_W-1:0]   wdata_i,
  input  wire logic                     split_2nd_i,   // Second half of a split access
  output logic                          misaligned_o,  // First half of a split access
  output logic                          ready_o,

  // Bus side
  output logic                          data_req_o,
  input  wire logic                     data_gnt_i,
  input  wire logic                     data_rvalid_i,
  output logic [`LSU_DATA_W-1:0]        data_addr_o,
  output logic                          data_we_o,
  output logic [`LSU_BE_W-1:0]          data_be_o,
  output logic [`LSU_DATA_W-1:0]        data_wdata_o,

  // Tracker side
  input  wire logic [`LSU_CNT_W-1:0]    cnt_i,         // Transactions in flight
  output logic                          trans_fire_o,  // req and gnt in this cycle
  output logic                          capture_o,     // Load response control
  output lsu_pkg::lsu_wb_ctrl_t         ctrl_o
);

  import lsu_pkg::*;

  localparam logic [`LSU_CNT_W-1:0] cnt_max = `LSU_MAX_OUTSTANDING;

  logic [`LSU_DATA_W-1:0] addr_int;   // Effective byte address
  logic [1:0]             offset;     // Byte offset within the word

  //////////////////////////////////////////////////
  // Address and split detection

  assign addr_int = use_incr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign offset   = addr_int[1:0];

  // Words off the boundary and halfwords at offset 3 need two bus accesses
  always_comb
  begin
    misaligned_o = 1'b0;
    if (lsu_en_i && !split_2nd_i)
    begin
      case (size_i)
        WORD:    misaligned_o = (offset != 2'b00);
        HALF:    misaligned_o = (offset == 2'b11);
        default: misaligned_o = 1'b0;        // Bytes never cross
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Byte enables

  always_comb
  begin
    case (size_i)
      BYTE:
      begin
        case (offset)
          2'b00: data_be_o = 4'b0001;
          2'b01: data_be_o = 4'b0010;
          2'b10: data_be_o = 4'b0100;
          2'b11: data_be_o = 4'b1000;
        endcase
      end
      HALF:
      begin
        if (split_2nd_i)
          data_be_o = 4'b0001;               // Upper byte lands in lane 0 of next word
        else
        begin
          case (offset)
            2'b00: data_be_o = 4'b0011;
            2'b01: data_be_o = 4'b0110;
            2'b10: data_be_o = 4'b1100;
            2'b11: data_be_o = 4'b1000;      // Lower byte only, rest follows
          endcase
        end
      end
      default:
      begin
        if (!split_2nd_i)
        begin
          case (offset)
            2'b00: data_be_o = 4'b1111;
            2'b01: data_be_o = 4'b1110;
            2'b10: data_be_o = 4'b1100;
            2'b11: data_be_o = 4'b1000;
          endcase
        end
        else
        begin
          // Remaining low lanes of the next word
          case (offset)
            2'b00: data_be_o = 4'b0000;      // Cannot occur
            2'b01: data_be_o = 4'b0001;
            2'b10: data_be_o = 4'b0011;
            2'b11: data_be_o = 4'b0111;
          endcase
        end
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Store data rotation

  // Rotate left by the offset so byte 0 sits in the addressed lane,
  // the bytes that wrap around serve the second half of a split store
  always_comb
  begin
    case (offset)
      2'b00: data_wdata_o = wdata_i;
      2'b01: data_wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'b10: data_wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      2'b11: data_wdata_o = {wdata_i[ 7:0], wdata_i[31: 8]};
    endcase
  end

  //////////////////////////////////////////////////
  // Request and readiness

  // Second half goes to the word boundary of the next word
  assign data_addr_o = split_2nd_i ? {addr_int[`LSU_DATA_W-1:2], 2'b00} : addr_int;
  assign data_we_o   = we_i;

  assign data_req_o   = lsu_en_i && (cnt_i < cnt_max);   // Held off when tracker is full
  assign trans_fire_o = data_req_o && data_gnt_i;

  // Stage advances only when the response side frees a slot in step
  assign ready_o = !lsu_en_i        ? 1'b1 :
                   (cnt_i == 2'd0)  ? trans_fire_o :
                   (cnt_i == 2'd1)  ? (trans_fire_o && data_rvalid_i) :
                                      data_rvalid_i;

  assign capture_o = ready_o && lsu_en_i;

  assign ctrl_o.size     = size_i;
  assign ctrl_o.sign_ext = sign_ext_i;
  assign ctrl_o.we       = we_i;
  assign ctrl_o.offset   = offset;
  assign ctrl_o.last     = !misaligned_o;  // Second halves and single accesses end the access

  // Tracker count and request gating stay consistent across both modules
  assert property (@(posedge clk) disable iff (!rst_n) (cnt_i == cnt_max) |-> !data_req_o)
    else $error("request raised with tracker full");

endmodule

`default_nettype wire

// ==== source/lsu_txn_tracker.sv ====
// Outstanding transaction counter, response control register and last granted address
`default_nettype none
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_txn_tracker
(
  input  wire logic                    clk,
  input  wire logic                    rst_n,

  input  wire logic                    trans_fire_i,   // Grant strobe
  input  wire logic                    req_pending_i,  // Request waiting for grant
  input  wire logic                    data_rvalid_i,  // Response strobe
  input  wire logic                    capture_i,      // Take ctrl_i for the response side
  input  wire lsu_pkg::lsu_wb_ctrl_t   ctrl_i,
  input  wire logic [`LSU_DATA_W-1:0]  addr_i,         // Issued bus address

  output logic [`LSU_CNT_W-1:0]        cnt_o,
  output logic                         busy_o,
  output lsu_pkg::lsu_wb_ctrl_t        wb_ctrl_o,
  output logic [`LSU_DATA_W-1:0]       wb_addr_o       // Address of last granted request
);

  import lsu_pkg::*;

  localparam logic [`LSU_CNT_W-1:0] cnt_max = `LSU_MAX_OUTSTANDING;

  logic [`LSU_CNT_W-1:0] cnt_q;
  logic [`LSU_CNT_W-1:0] next_cnt;
  lsu_wb_ctrl_t          ctrl_q;

  //////////////////////////////////////////////////
  // Outstanding counter

  // Grant and response in the same cycle cancel out
  always_comb
  begin
    case ({trans_fire_i, data_rvalid_i})
      2'b10:   next_cnt = cnt_q + 1'b1;
      2'b01:   next_cnt = cnt_q - 1'b1;
      default: next_cnt = cnt_q;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else
      cnt_q <= next_cnt;
  end

  assign cnt_o  = cnt_q;
  assign busy_o = (cnt_q != '0) || req_pending_i;   // Includes a request still waiting for gnt

  //////////////////////////////////////////////////
  // Response control

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      ctrl_q <= '0;
    else if (capture_i)
      ctrl_q <= ctrl_i;                // Valid until the matching rvalid
  end

  assign wb_ctrl_o = ctrl_q;

  // Kept for error reporting, follows every grant
  always_ff @(posedge clk)
  begin
    if (trans_fire_i)
      wb_addr_o <= addr_i;
  end

  // Responses only answer granted requests
  assert property (@(posedge clk) disable iff (!rst_n) data_rvalid_i |-> (cnt_q != '0))
    else $error("rvalid with no transaction in flight");

  // Request gating keeps the count in range
  assert property (@(posedge clk) disable iff (!rst_n) cnt_q <= cnt_max)
    else $error("outstanding count above maximum");

endmodule

`default_nettype wire

// ==== source/lsu_response_stage.sv ====
// Response stage with load data alignment, sign extension and split access merge
`default_nettype none
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_response_stage
(
  input  wire logic                    clk,
  input  wire logic                    rst_n,

  // Bus side
  input  wire logic                    data_rvalid_i,
  input  wire logic [`LSU_DATA_W-1:0]  data_rdata_i,
  input  wire logic                    data_err_i,

  // Tracker side
  input  wire lsu_pkg::lsu_wb_ctrl_t   wb_ctrl_i,      // Control of the oldest access
  input  wire logic [`LSU_CNT_W-1:0]   cnt_i,

  // Write-back
  output logic                         wb_valid_o,
  output logic [`LSU_DATA_W-1:0]       wb_rdata_o,
  output logic                         wb_err_o
);

  import lsu_pkg::*;

  logic [`LSU_DATA_W-1:0] rdata_q;       // First half of a split load or the last result
  logic [`LSU_DATA_W-1:0] rdata_ext;     // Aligned and extended load result
  logic [`LSU_DATA_W-1:0] rdata_w_ext;
  logic [`LSU_DATA_W-1:0] rdata_h_ext;
  logic [`LSU_DATA_W-1:0] rdata_b_ext;
  logic [15:0]            half_raw;
  logic [7:0]             byte_raw;

  //////////////////////////////////////////////////
  // Alignment

  // Words off the boundary join the saved lower bytes with the new word
  always_comb
  begin
    case (wb_ctrl_i.offset)
      2'b00: rdata_w_ext = data_rdata_i;
      2'b01: rdata_w_ext = {data_rdata_i[ 7:0], rdata_q[31: 8]};
      2'b10: rdata_w_ext = {data_rdata_i[15:0], rdata_q[31:16]};
      2'b11: rdata_w_ext = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb
  begin
    case (wb_ctrl_i.offset)
      2'b00: half_raw = data_rdata_i[15: 0];
      2'b01: half_raw = data_rdata_i[23: 8];
      2'b10: half_raw = data_rdata_i[31:16];
      2'b11: half_raw = {data_rdata_i[7:0], rdata_q[31:24]};  // Crosses into next word
    endcase
  end

  always_comb
  begin
    case (wb_ctrl_i.offset)
      2'b00: byte_raw = data_rdata_i[ 7: 0];
      2'b01: byte_raw = data_rdata_i[15: 8];
      2'b10: byte_raw = data_rdata_i[23:16];
      2'b11: byte_raw = data_rdata_i[31:24];
    endcase
  end

  //////////////////////////////////////////////////
  // Extension

  assign rdata_h_ext = wb_ctrl_i.sign_ext ? {{16{half_raw[15]}}, half_raw}
                                          : {16'h0000, half_raw};
  assign rdata_b_ext = wb_ctrl_i.sign_ext ? {{24{byte_raw[7]}}, byte_raw}
                                          : {24'h00_0000, byte_raw};

  always_comb
  begin
    case (wb_ctrl_i.size)
      BYTE:    rdata_ext = rdata_b_ext;
      HALF:    rdata_ext = rdata_h_ext;
      default: rdata_ext = rdata_w_ext;
    endcase
  end

  // Raw word of a first half feeds the merge
  // A finished load keeps its result for the idle output
  always_ff @(posedge clk)
  begin
    if (data_rvalid_i && !wb_ctrl_i.we)
    begin
      if (!wb_ctrl_i.last)
        rdata_q <= data_rdata_i;
      else
        rdata_q <= rdata_ext;
    end
  end

  //////////////////////////////////////////////////
  // Write-back outputs

  assign wb_rdata_o = data_rvalid_i ? rdata_ext : rdata_q;
  assign wb_valid_o = data_rvalid_i && wb_ctrl_i.last;   // One pulse per complete access
  assign wb_err_o   = data_rvalid_i && data_err_i;

  // The control in use must belong to a transaction still in flight
  assert property (@(posedge clk) disable iff (!rst_n) data_rvalid_i |-> (cnt_i != '0))
    else $error("response without tracked transaction");

endmodule

`default_nettype wire

// ==== source/lsu_top.sv ====
// Load/store unit top level joining request stage, transaction tracker and response stage
`default_nettype none
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_top
(
  input  wire logic                    clk,
  input  wire logic                    rst_n,

  // Core side
  input  wire logic                    lsu_en_i,
  input  wire logic [`LSU_DATA_W-1:0]  operand_a_i,
  input  wire logic [`LSU_DATA_W-1:0]  operand_b_i,
  input  wire logic                    use_incr_i,
  input  wire lsu_pkg::lsu_size_e      size_i,
  input  wire logic                    sign_ext_i,
  input  wire logic                    we_i,
  input  wire logic [`LSU_DATA_W-1:0]  wdata_i,
  input  wire logic                    split_2nd_i,
  output logic                         misaligned_o,
  output logic                         ready_o,
  output logic                         busy_o,

  // Write-back
  output logic                         wb_valid_o,
  output logic [`LSU_DATA_W-1:0]       wb_rdata_o,
  output logic                         wb_err_o,
  output logic [`LSU_DATA_W-1:0]       wb_addr_o,

  // Data bus
  output logic                         data_req_o,
  input  wire logic                    data_gnt_i,
  output logic [`LSU_DATA_W-1:0]       data_addr_o,
  output logic                         data_we_o,
  output logic [`LSU_BE_W-1:0]         data_be_o,
  output logic [`LSU_DATA_W-1:0]       data_wdata_o,
  input  wire logic                    data_rvalid_i,
  input  wire logic [`LSU_DATA_W-1:0]  data_rdata_i,
  input  wire logic                    data_err_i
);

  import lsu_pkg::*;

  logic                  trans_fire;   // Grant strobe
  logic                  capture;
  lsu_wb_ctrl_t          ctrl_next;    // Control of the access being accepted
  lsu_wb_ctrl_t          wb_ctrl;      // Control of the oldest access
  logic [`LSU_CNT_W-1:0] cnt_q;

  //////////////////////////////////////////////////
  // Pipeline

  lsu_request_stage i_request (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_en_i     (lsu_en_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .use_incr_i   (use_incr_i),
    .size_i       (size_i),
    .sign_ext_i   (sign_ext_i),
    .we_i         (we_i),
    .wdata_i      (wdata_i),
    .split_2nd_i  (split_2nd_i),
    .misaligned_o (misaligned_o),
    .ready_o      (ready_o),
    .data_req_o   (data_req_o),
    .data_gnt_i   (data_gnt_i),
    .data_rvalid_i(data_rvalid_i),
    .data_addr_o  (data_addr_o),
    .data_we_o    (data_we_o),
    .data_be_o    (data_be_o),
    .data_wdata_o (data_wdata_o),
    .cnt_i        (cnt_q),
    .trans_fire_o (trans_fire),
    .capture_o    (capture),
    .ctrl_o       (ctrl_next)
  );

  lsu_txn_tracker i_tracker (
    .clk          (clk),
    .rst_n        (rst_n),
    .trans_fire_i (trans_fire),
    .req_pending_i(data_req_o),      // Pending request keeps the unit busy
    .data_rvalid_i(data_rvalid_i),
    .capture_i    (capture),
    .ctrl_i       (ctrl_next),
    .addr_i       (data_addr_o),
    .cnt_o        (cnt_q),
    .busy_o       (busy_o),
    .wb_ctrl_o    (wb_ctrl),
    .wb_addr_o    (wb_addr_o)
  );

  lsu_response_stage i_response (
    .clk          (clk),
    .rst_n        (rst_n),
    .data_rvalid_i(data_rvalid_i),
    .data_rdata_i (data_rdata_i),
    .data_err_i   (data_err_i),
    .wb_ctrl_i    (wb_ctrl),
    .cnt_i        (cnt_q),
    .wb_valid_o   (wb_valid_o),
    .wb_rdata_o   (wb_rdata_o),
    .wb_err_o     (wb_err_o)
  );

endmodule

`default_nettype wire

// ==== test/lsu_tb_bus_model.sv ====
// Data memory model with random grant and response delays, store log and error injection
`default_nettype none
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_tb_bus_model
#(
  parameter logic [31:0] SEED     = 32'h103f_3e98,
  parameter int          ERR_WORD = 63              // Word that answers with an error
)
(
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    hold_gnt_i,  // Withhold all grants
  input  wire logic                    data_req_i,
  input  wire logic [`LSU_DATA_W-1:0]  data_addr_i,
  input  wire logic                    data_we_i,
  input  wire logic [`LSU_BE_W-1:0]    data_be_i,
  input  wire logic [`LSU_DATA_W-1:0]  data_wdata_i,
  output logic                         data_gnt_o,
  output logic                         data_rvalid_o,
  output logic [`LSU_DATA_W-1:0]       data_rdata_o,
  output logic                         data_err_o
);

  logic [`LSU_DATA_W-1:0] mem [64];
  logic [`LSU_BE_W-1:0]   be_log [$];       // Enables of every granted store
  int unsigned            q_due [$];        // Cycle of each rvalid in grant order
  logic [`LSU_DATA_W-1:0] q_rdata [$];
  logic                   q_err [$];
  logic [31:0]            lfsr;
  int unsigned            cyc;              // Rising edges since reset
  int unsigned            due;              // Earliest rvalid cycle of a new grant
  int unsigned            last_due;
  int unsigned            gnt_wait;         // Cycles left before the next grant
  logic                   hold_q;

  // Galois LFSR stepped once per bit taken
  function automatic int unsigned draw(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  initial
  begin
    lfsr          = SEED ^ 32'h0000_5a5a;   // Own stream apart from the stimulus
    cyc           = 0;
    due           = 0;
    last_due      = 0;
    gnt_wait      = 0;
    hold_q        = 1'b0;
    data_gnt_o    = 1'b0;
    data_rvalid_o = 1'b0;
    data_rdata_o  = '0;
    data_err_o    = 1'b0;
    // Every byte differs since 29 is odd and the map over 256 addresses is one to one
    for (int w = 0; w < 64; w++)
      for (int b = 0; b < 4; b++)
        mem[w][8*b +: 8] = 8'((w*4 + b) * 29) ^ 8'h96;
  end

  //////////////////////////////////////////////////
  // Bus sampling on the rising edge

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      cyc++;
      hold_q = hold_gnt_i;
      if (data_rvalid_o)
      begin
        void'(q_due.pop_front());
        void'(q_rdata.pop_front());
        void'(q_err.pop_front());
      end
      if (data_req_i && data_gnt_o)
      begin
        // Read data taken at grant keeps program order with later stores
        q_rdata.push_back(mem[data_addr_i[7:2]]);
        q_err.push_back(data_addr_i[7:2] == ERR_WORD);
        if (data_we_i)
        begin
          for (int b = 0; b < 4; b++)
            if (data_be_i[b])
              mem[data_addr_i[7:2]][8*b +: 8] = data_wdata_i[8*b +: 8];
          be_log.push_back(data_be_i);
        end
        due      = cyc + 1 + draw(2) % 3;   // 1 .. 3 cycles after the grant
        last_due = (due > last_due) ? due : last_due + 1;
        q_due.push_back(last_due);
        gnt_wait = draw(2);                 // 0 .. 3 cycles
      end
      else if (gnt_wait != 0)
        gnt_wait--;
    end
  end

  //////////////////////////////////////////////////
  // Bus outputs on the falling edge

  always @(negedge clk)
  begin
    data_gnt_o = rst_n && !hold_q && (gnt_wait == 0);
    if (q_due.size() != 0 && q_due[0] == cyc + 1)
    begin
      data_rvalid_o = 1'b1;
      data_rdata_o  = q_rdata[0];
      data_err_o    = q_err[0];
    end
    else
    begin
      data_rvalid_o = 1'b0;
      data_rdata_o  = '0;
      data_err_o    = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== test/lsu_tb.sv ====
// Testbench top with clock, reset, access driver, load reference, result checks and timeout
`default_nettype none
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_tb;

  import lsu_pkg::*;

  localparam int          N_ACC       = 75;               // Accesses over all tests
  localparam int          CYCLE_LIMIT = N_ACC * 16 + 200;
  localparam logic [31:0] SEED        = 32'h103f_3e98;
  localparam int          ERR_WORD    = 63;

  logic clk, rst_n, lsu_en_i, use_incr_i, sign_ext_i, we_i, split_2nd_i;
  logic [`LSU_DATA_W-1:0] operand_a_i, operand_b_i, wdata_i;
  lsu_size_e size_i;
  logic misaligned_o, ready_o, busy_o, wb_valid_o, wb_err_o;
  logic [`LSU_DATA_W-1:0] wb_rdata_o, wb_addr_o;
  logic data_req_o, data_gnt_i, data_we_o, data_rvalid_i, data_err_i, hold_gnt;
  logic [`LSU_DATA_W-1:0] data_addr_o, data_wdata_o, data_rdata_i;
  logic [`LSU_BE_W-1:0] data_be_o;

  logic [7:0]             img [256];      // Expected memory, byte per address
  logic [`LSU_DATA_W-1:0] exp_data [$];   // Expected write-backs in order
  logic                   exp_load [$];
  logic                   exp_err [$];
  logic [`LSU_DATA_W-1:0] exp_addr [$];
  logic [31:0]            lfsr;
  int unsigned            cycles;

  lsu_top i_dut (.*);

  lsu_tb_bus_model #(.SEED(SEED), .ERR_WORD(ERR_WORD)) i_mem (
    .clk(clk), .rst_n(rst_n), .hold_gnt_i(hold_gnt),
    .data_req_i(data_req_o), .data_addr_i(data_addr_o), .data_we_i(data_we_o),
    .data_be_i(data_be_o), .data_wdata_i(data_wdata_o), .data_gnt_o(data_gnt_i),
    .data_rvalid_o(data_rvalid_i), .data_rdata_o(data_rdata_i), .data_err_o(data_err_i)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Little-endian gather of 1, 2 or 4 bytes from the image and extension
  function automatic logic [31:0] lsu_ref_load(input logic [7:0] addr, input lsu_size_e size,
                                                input logic sgn);
    logic [31:0] v;
    v = {img[addr + 8'd3], img[addr + 8'd2], img[addr + 8'd1], img[addr]};
    case (size)
      BYTE:    return sgn ? {{24{v[7]}}, v[7:0]} : {24'h0, v[7:0]};
      HALF:    return sgn ? {{16{v[15]}}, v[15:0]} : {16'h0, v[15:0]};
      default: return v;
    endcase
  endfunction

  function automatic int size_bytes(input lsu_size_e size);
    return (size == BYTE) ? 1 : (size == HALF) ? 2 : 4;
  endfunction

  task automatic stop_on_error();
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [`LSU_DATA_W-1:0] exp,
                            input logic [`LSU_DATA_W-1:0] act);
    if (act !== exp)
    begin
      $display("** Error @ %0t: %s expected %h actual %h", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_be(input string name, input logic [`LSU_BE_W-1:0] exp,
                          input logic [`LSU_BE_W-1:0] act);
    if (act !== exp)
    begin
      $display("** Error @ %0t: %s expected %b actual %b", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("** Error @ %0t: %s expected %b actual %b", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  //////////////////////////////////////////////////
  // Access driver

  // Address split at random between base and offset, or base only
  task automatic drive_access(input logic [31:0] addr, input lsu_size_e size, input logic sgn,
                              input logic we, input logic [31:0] wdata, input logic second);
    logic [31:0] ofs;
    ofs         = rand_bits(8);
    lsu_en_i    = 1'b1;
    size_i      = size;
    sign_ext_i  = sgn;
    we_i        = we;
    wdata_i     = wdata;
    split_2nd_i = second;
    use_incr_i  = 1'(rand_bits(1));
    operand_a_i = use_incr_i ? addr - ofs : addr;
    operand_b_i = ofs;
  endtask

  task automatic wait_ready();
    @(posedge clk);
    while (!ready_o)
      @(posedge clk);
  endtask

  // Leaves the access on the inputs, so a following call runs back to back
  task automatic do_access(input logic [31:0] addr, input lsu_size_e size, input logic sgn,
                           input logic we, input logic [31:0] wdata);
    int  n;
    logic split;
    n     = size_bytes(size);
    split = (addr[1:0] + n) > 4;
    exp_load.push_back(!we);
    exp_data.push_back(we ? 32'h0 : lsu_ref_load(addr[7:0], size, sgn));
    exp_err.push_back(addr[7:2] == ERR_WORD);
    exp_addr.push_back(addr);
    if (we)
      for (int b = 0; b < n; b++)
        img[addr[7:0] + b] = wdata[8*b +: 8];
    @(negedge clk);
    drive_access(addr, size, sgn, we, wdata, 1'b0);
    wait_ready();
    check_bit("misaligned_o", split, misaligned_o);
    if (split)
    begin
      @(negedge clk);
      drive_access(addr + 4, size, sgn, we, wdata, 1'b1);  // Next word at the same offset
      wait_ready();
      check_bit("misaligned_o", 1'b0, misaligned_o);
    end
  endtask

  task automatic go_idle();
    @(negedge clk);
    lsu_en_i    = 1'b0;
    split_2nd_i = 1'b0;
  endtask

  // Unit goes idle once every expected write-back has arrived
  task automatic drain();
    @(negedge clk);
    while (exp_data.size() != 0)
      @(negedge clk);
    check_bit("busy_o", 1'b0, busy_o);
  endtask

  // Lanes covered by the bytes of a store over the first and the next word
  task automatic check_store(input logic [31:0] addr, input lsu_size_e size);
    logic [7:0] lanes;
    lanes = 8'(((1 << size_bytes(size)) - 1) << addr[1:0]);
    if (i_mem.be_log.size() == 0)
    begin
      $display("Store at %h reached the memory without a granted write", addr);
      stop_on_error();
    end
    check_be("data_be_o", lanes[3:0], i_mem.be_log.pop_front());
    if (lanes[7:4] != 4'h0)
      check_be("data_be_o", lanes[7:4], i_mem.be_log.pop_front());
    for (int w = 0; w < 2; w++)
      check_word("mem", {img[{addr[7:2], 2'b11} + 4*w], img[{addr[7:2], 2'b10} + 4*w],
                         img[{addr[7:2], 2'b01} + 4*w], img[{addr[7:2], 2'b00} + 4*w]},
                 i_mem.mem[addr[7:2] + w]);
  endtask

  //////////////////////////////////////////////////
  // Response compare and timeout

  always @(posedge clk)
  begin
    if (rst_n && wb_valid_o)
    begin
      if (exp_data.size() == 0)
      begin
        $display("Write-back pulse with no access outstanding at %0t", $time);
        stop_on_error();
      end
      if (exp_load[0])
        check_word("wb_rdata_o", exp_data[0], wb_rdata_o);
      check_bit("wb_err_o", exp_err[0], wb_err_o);
      if (exp_err[0])
        check_word("wb_addr_o", exp_addr[0], wb_addr_o);
      void'(exp_data.pop_front());
      void'(exp_load.pop_front());
      void'(exp_err.pop_front());
      void'(exp_addr.pop_front());
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("Run exceeded %0d cycles without finishing", CYCLE_LIMIT);
      stop_on_error();
    end
  end

  //////////////////////////////////////////////////
  // Stimulus

  initial
  begin
    lfsr = SEED;
    cycles = 0;
    rst_n = 1'b0;
    hold_gnt = 1'b0;
    lsu_en_i = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    use_incr_i = 1'b0;
    size_i = WORD;
    sign_ext_i = 1'b0;
    we_i = 1'b0;
    wdata_i = '0;
    split_2nd_i = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int a = 0; a < 256; a++)
      img[a] = i_mem.mem[a / 4][8*(a % 4) +: 8];

    // Aligned word store then load
    do_access(32'h10, WORD, 1'b0, 1'b1, rand_bits(32));
    go_idle();
    check_store(32'h10, WORD);
    do_access(32'h10, WORD, 1'b0, 1'b0, '0);
    go_idle();
    drain();

    // Bytes and halfwords that stay inside a word
    for (int s = 0; s < 2; s++)
    begin
      for (int o = 0; o < 4; o++)
        do_access(32'h20 + o, BYTE, s[0], 1'b0, '0);
      for (int o = 0; o < 3; o++)
        do_access(32'h24 + o, HALF, s[0], 1'b0, '0);
    end
    go_idle();
    drain();

    // Split loads
    for (int o = 1; o < 4; o++)
      do_access(32'h30 + o, WORD, 1'b0, 1'b0, '0);
    do_access(32'h37, HALF, 1'b0, 1'b0, '0);
    do_access(32'h3b, HALF, 1'b1, 1'b0, '0);
    go_idle();
    drain();

    // Stores of every size and offset
    for (int s = 0; s < 3; s++)
      for (int o = 0; o < 4; o++)
      begin
        do_access(32'h80 + 8*(4*s + o) + o, lsu_size_e'(s), 1'b0, 1'b1, rand_bits(32));
        go_idle();
        check_store(32'h80 + 8*(4*s + o) + o, lsu_size_e'(s));
      end
    drain();

    // Bus error on the flagged word
    do_access(ERR_WORD * 4, WORD, 1'b0, 1'b0, '0);
    go_idle();
    drain();

    // Grant withheld for a few cycles
    @(negedge clk);
    hold_gnt = 1'b1;
    exp_load.push_back(1'b1);
    exp_data.push_back(lsu_ref_load(8'h44, WORD, 1'b0));
    exp_err.push_back(1'b0);
    exp_addr.push_back(32'h44);
    @(negedge clk);
    drive_access(32'h44, WORD, 1'b0, 1'b0, '0, 1'b0);
    repeat (4)
    begin
      @(posedge clk);
      check_bit("data_req_o", 1'b1, data_req_o);
      check_bit("ready_o", 1'b0, ready_o);
      check_bit("busy_o", 1'b1, busy_o);
    end
    @(negedge clk);
    hold_gnt = 1'b0;
    wait_ready();
    go_idle();
    drain();

    // Random overlapping accesses that keep split words clear of the flagged word
    for (int i = 0; i < 40; i++)
    begin
      do_access({6'(rand_bits(6) % 62), 2'(rand_bits(2))}, lsu_size_e'(rand_bits(2) % 3),
                1'(rand_bits(1)), rand_bits(2) == 0, rand_bits(32));
      if (rand_bits(2) == 0)
        go_idle();
    end
    go_idle();
    drain();
    for (int w = 0; w < 64; w++)
      check_word("mem", {img[4*w+3], img[4*w+2], img[4*w+1], img[4*w]}, i_mem.mem[w]);

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+source
source/lsu_pkg.sv
source/lsu_request_stage.sv
source/lsu_txn_tracker.sv
source/lsu_response_stage.sv
source/lsu_top.sv
test/lsu_tb_bus_model.sv
test/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - include_dirs:
      - source
    files:
      - source/lsu_pkg.sv
      - source/lsu_request_stage.sv
      - source/lsu_txn_tracker.sv
      - source/lsu_response_stage.sv
      - source/lsu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/lsu_tb_bus_model.sv
      - test/lsu_tb.sv
